// File: Makefile
VERILATOR ?= verilator
TOP ?= colorMapperTb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS ?=
RUNFLAGS ?= +verilator+error+limit+1000
PASS_TEXT ?= No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --assert $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/colorMapperCases.txt
# F moving direction(0 up, 1 right, 2 down, 3 left) keycode(hex) ticks
# P drawX drawY blank expected-mapAddr expected-rgb(hex)
P 100 50 1 3865 926d55
P 200 100 0 8050 000000
F 0 0 00 1
P 10 20 1 1602 6ddbaa
F 0 0 2c 1
P 0 0 1 8025 49db55
P 311 340 1 35302 883818
P 322 340 1 35305 ff4955
P 315 341 1 35303 b08820
F 1 0 00 1
P 311 340 1 34982 181818
F 1 0 00 8
P 0 0 1 7065 92db55
P 311 340 1 34342 883818
F 1 0 00 8
P 311 340 1 33702 e83020
F 1 1 00 1
P 311 340 1 33702 888888
F 1 3 00 1
F 1 3 00 420
P 0 0 1 0 000000
P 310 0 1 0 000000
P 315 0 1 6401 000055
P 400 0 1 6422 00b6aa
F 1 0 00 1
F 1 0 00 430
P 400 340 1 22 00b6aa
P 400 339 1 0 000000
P 2000 400 1 5222 000000

// File: bench/colorMapperTb.sv
`timescale 1ns/100ps

module colorMapperTb import colorMapperPkg::*; ();

	localparam int clkPeriod = 8;
	localparam int resetCycles = 4;
	localparam int pipeDepth = 2;
	localparam int maxLines = 200;
	localparam int maxTicks = 1000;
	localparam int watchdogCycles = 20000;
	localparam string casesPath = "bench/colorMapperCases.txt";

	logic Clk;
	logic rstN;
	logic [7:0] keycode;
	logic moving;
	facingT direction;
	logic frameTick;
	screenCoordT drawX;
	screenCoordT drawY;
	logic blank;
	spriteIndexT spriteData = '0;
	colorIndexT mapData = '0;
	colorIndexT startData = '0;
	spriteAddrT spriteAddr;
	imageAddrT mapAddr;
	imageAddrT startAddr;
	rgbT rgb;

	int errorCount;
	int checkCount;

	colorMapper dut0 (
		.Clk, .rstN, .keycode, .moving, .direction, .frameTick,
		.drawX, .drawY, .blank, .spriteData, .mapData, .startData,
		.spriteAddr, .mapAddr, .startAddr, .rgb
	);

	bind colorMapper colorMapperProperties props0 (
		.Clk, .rstN, .drawX, .drawY, .blank, .spriteAddr, .rgb, .camera
	);

	initial Clk = 1'b0;
	always #(clkPeriod / 2) Clk = ~Clk;

	// Block RAM models with one cycle of read latency
	always @(posedge Clk) begin
		spriteData <= spriteAddr[3:0];
		mapData <= mapAddr[7:0];
		startData <= ~startAddr[7:0];
	end

	task automatic applyTicks(input logic move, input facingT dir, input logic [7:0] key,
			input int ticks);
		if (ticks > maxTicks) begin
			errorCount++;
			$display("Tick count %0d is above the limit of %0d", ticks, maxTicks);
			return;
		end
		for (int i = 0; i < ticks; i++) begin
			@(posedge Clk);
			moving <= move;
			direction <= dir;
			keycode <= key;
			frameTick <= 1'b1;
			@(posedge Clk);
			frameTick <= 1'b0;
		end
	endtask

	task automatic checkPixel(input screenCoordT x, input screenCoordT y, input logic vis,
			input imageAddrT expMap, input rgbT expRgb);
		@(posedge Clk);
		drawX <= x;
		drawY <= y;
		blank <= vis;
		// Address stage takes the pixel on this edge
		@(posedge Clk);
		@(negedge Clk);
		checkCount++;
		assert (mapAddr == expMap) else begin
			errorCount++;
			$display("** Error at %t: mapAddr = %0d, expected %0d (pixel %0d,%0d)",
				$time, mapAddr, expMap, x, y);
		end
		repeat (pipeDepth) @(posedge Clk);
		@(negedge Clk);
		checkCount++;
		assert (rgb == expRgb) else begin
			errorCount++;
			$display("** Error at %t: rgb = %06h, expected %06h (pixel %0d,%0d)",
				$time, rgb, expRgb, x, y);
		end
	endtask

	task automatic runCases();
		int fd;
		int got;
		int fields;
		int lineNo;
		string line;
		string rest;
		byte cmd;
		int a, b, c, d, e;
		fd = $fopen(casesPath, "r");
		if (fd == 0) begin
			errorCount++;
			$display("Cannot open the case file %s", casesPath);
			return;
		end
		lineNo = 0;
		while (lineNo < maxLines) begin
			got = $fgets(line, fd);
			if (got == 0) break;
			lineNo++;
			cmd = line.getc(0);
			if (cmd == "#" || cmd == "\n") continue;
			rest = line.substr(1, line.len() - 1);
			if (cmd == "F") begin
				fields = $sscanf(rest, "%d %d %h %d", a, b, c, d);
				if (fields == 4) begin
					applyTicks(a != 0, facingT'(b[1:0]), 8'(c), d);
				end else begin
					errorCount++;
					$display("Line %0d of the case file is malformed", lineNo);
				end
			end else if (cmd == "P") begin
				fields = $sscanf(rest, "%d %d %d %d %h", a, b, c, d, e);
				if (fields == 5) begin
					checkPixel(screenCoordT'(a), screenCoordT'(b), c != 0,
						imageAddrT'(d), rgbT'(e));
				end else begin
					errorCount++;
					$display("Line %0d of the case file is malformed", lineNo);
				end
			end else begin
				errorCount++;
				$display("Unknown command on line %0d of the case file", lineNo);
			end
		end
		if (lineNo >= maxLines) begin
			errorCount++;
			$display("Case file has more than %0d lines", maxLines);
		end
		$fclose(fd);
	endtask

	initial begin
		$timeformat(-9, 1, " ns", 0);
		errorCount = 0;
		checkCount = 0;
		rstN = 1'b0;
		keycode = '0;
		moving = 1'b0;
		direction = faceUp;
		frameTick = 1'b0;
		drawX = '0;
		drawY = '0;
		blank = 1'b0;
		repeat (resetCycles) @(posedge Clk);
		rstN <= 1'b1;
		runCases();
		if (checkCount == 0) begin
			errorCount++;
			$display("No pixel checks were run");
		end
		if (dut0.props0.failures != 0) begin
			$display("Bound assertions failed %0d times", dut0.props0.failures);
			errorCount += dut0.props0.failures;
		end
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin
		#(watchdogCycles * clkPeriod);
		$display("Timeout, the run did not finish within %0d cycles", watchdogCycles);
		$display("Errors found");
		$finish;
	end

endmodule

// File: bench/colorMapper_properties.sv
`timescale 1ns/100ps

module colorMapperProperties import colorMapperPkg::*; (
	input logic Clk,
	input logic rstN,
	input screenCoordT drawX,
	input screenCoordT drawY,
	input logic blank,
	input spriteAddrT spriteAddr,
	input rgbT rgb,
	input cameraPosT camera
);

	int blankFails = 0;
	int spriteFails = 0;
	int cameraFails = 0;
	int failures;
	logic inWindow;

	assign failures = blankFails + spriteFails + cameraFails;

	assign inWindow = (drawX >= charLeft) && (drawX <= charRight)
		&& (drawY >= charTop) && (drawY <= charBottom);

	// Pixel sampled three edges back has reached rgb by now
	blankIsBlack: assert property (@(posedge Clk) disable iff (!rstN)
		!$past(blank, 3) |-> rgb == rgbBlack)
		else begin
			$error("rgb is %06h for a blanked pixel", rgb);
			blankFails++;
		end

	spriteOutside: assert property (@(posedge Clk) disable iff (!rstN)
		!$past(inWindow) |-> spriteAddr == '0)
		else begin
			$error("spriteAddr is %0d outside the character window", spriteAddr);
			spriteFails++;
		end

	// Upper bounds may be passed by one step
	cameraInBounds: assert property (@(posedge Clk) disable iff (!rstN)
		camera.x >= cameraMinX && camera.x <= cameraMaxX + 1
		&& camera.y >= cameraMinY && camera.y <= cameraMaxY + 1)
		else begin
			$error("camera (%0d, %0d) is out of bounds", camera.x, camera.y);
			cameraFails++;
		end

endmodule

// File: logic/colorMapper.sv
`timescale 1ns/100ps

module colorMapper import colorMapperPkg::*; (
	input logic Clk,
	input logic rstN,
	input logic [7:0] keycode,
	input logic moving,
	input facingT direction,
	input logic frameTick,
	input screenCoordT drawX,
	input screenCoordT drawY,
	input logic blank,
	input spriteIndexT spriteData,
	input colorIndexT mapData,
	input colorIndexT startData,
	output spriteAddrT spriteAddr,
	output imageAddrT mapAddr,
	output imageAddrT startAddr,
	output rgbT rgb
);

	animFrameT animFrame;
	cameraStepT step;
	cameraPosT camera;
	gameStateT gameState;
	pixelTagT tag;

	// Frame-rate side
	walkAnimator animator0 (
		.Clk, .rstN, .frameTick, .moving, .direction,
		.animFrame, .step
	);

	sceneControl scene0 (
		.Clk, .rstN, .frameTick, .keycode, .step,
		.gameState, .camera
	);

	// Pixel side, two stages around the external memories
	pixelAddressGen addrGen0 (
		.Clk, .rstN, .drawX, .drawY, .blank,
		.animFrame, .camera, .gameState,
		.spriteAddr, .mapAddr, .startAddr, .tag
	);

	pixelColor color0 (
		.Clk, .rstN, .tag, .spriteData, .mapData, .startData,
		.rgb
	);

endmodule

// File: logic/colorMapperPkg.sv
package colorMapperPkg;

	typedef logic [10:0] screenCoordT;
	typedef logic signed [12:0] worldCoordT;
	typedef logic [12:0] spriteAddrT;
	typedef logic [18:0] imageAddrT;
	typedef logic [7:0] colorIndexT;
	typedef logic [3:0] spriteIndexT;
	typedef logic [23:0] rgbT;

	// Encoding matches the direction input from the keyboard logic
	typedef enum logic [1:0] {faceUp, faceRight, faceDown, faceLeft} facingT;
	typedef enum logic [1:0] {rest1, move1, rest2, move2} walkPhaseT;
	typedef enum logic {gameStart, gameOverworld} gameStateT;

	typedef struct packed {
		facingT facing;
		walkPhaseT phase;
	} animFrameT;

	typedef struct packed {
		logic active;
		facingT dir;
	} cameraStepT;

	typedef struct packed {
		worldCoordT x;
		worldCoordT y;
	} cameraPosT;

	typedef struct packed {
		logic blank;
		logic characterHere;
		logic inMap;
		logic isOverworld;
	} pixelTagT;

	localparam logic [7:0] startKey = 8'h2c;

	// Player sprite window, fixed at screen centre
	localparam screenCoordT charLeft = 11'd311;
	localparam screenCoordT charRight = 11'd329;
	localparam screenCoordT charTop = 11'd340;
	localparam screenCoordT charBottom = 11'd368;

	localparam spriteAddrT spriteStride = 13'd228;
	localparam spriteAddrT frameWidth = 13'd19;

	localparam imageAddrT mapWidth = 19'd320;
	localparam imageAddrT mapHeight = 19'd240;
	localparam imageAddrT mapScale = 19'd4;
	localparam imageAddrT startWidth = 19'd320;
	localparam imageAddrT startScale = 19'd2;

	localparam worldCoordT cameraStart = 13'sd100;
	localparam worldCoordT cameraMinX = -13'sd311;
	localparam worldCoordT cameraMaxX = 13'sd951;
	localparam worldCoordT cameraMinY = -13'sd340;
	localparam worldCoordT cameraMaxY = 13'sd594;

	localparam int stepPeriod = 8;

	localparam rgbT rgbBlack = 24'h000000;

	// Index 0 is never shown, the map shows through instead
	localparam rgbT characterPalette [16] = '{
		24'h000000, 24'hf8f8f8, 24'h181818, 24'hf8b888,
		24'hd87050, 24'h883818, 24'h3050c8, 24'h1828a0,
		24'he83020, 24'h901810, 24'h48a848, 24'h206820,
		24'hf0d040, 24'hb08820, 24'h888888, 24'h505050
	};

endpackage

// File: logic/pixelAddressGen.sv
`timescale 1ns/100ps

module pixelAddressGen import colorMapperPkg::*; (
	input logic Clk,
	input logic rstN,
	input screenCoordT drawX,
	input screenCoordT drawY,
	input logic blank,
	input animFrameT animFrame,
	input cameraPosT camera,
	input gameStateT gameState,
	output spriteAddrT spriteAddr,
	output imageAddrT mapAddr,
	output imageAddrT startAddr,
	output pixelTagT tag
);

	worldCoordT worldX, worldY;
	imageAddrT mapCol, mapRow;
	logic onWorld, inMapNext, characterNext;
	spriteAddrT frameSlot, spriteNext;
	imageAddrT mapNext, startNext;

	always_comb begin
		worldX = $signed({2'b00, drawX}) + camera.x;
		worldY = $signed({2'b00, drawY}) + camera.y;
		onWorld = !worldX[12] && !worldY[12];
		mapCol = imageAddrT'(worldX) / mapScale;
		mapRow = imageAddrT'(worldY) / mapScale;
		inMapNext = onWorld && (mapCol < mapWidth) && (mapRow < mapHeight);
		mapNext = onWorld ? mapRow * mapWidth + mapCol : '0;

		startNext = imageAddrT'(drawY) / startScale * startWidth
			+ imageAddrT'(drawX) / startScale;

		// Sheet order is down, left, up, right with three slots each
		case (animFrame.facing)
			faceDown: frameSlot = 13'd0;
			faceLeft: frameSlot = 13'd3;
			faceUp: frameSlot = 13'd6;
			default: frameSlot = 13'd9;
		endcase
		case (animFrame.phase)
			move1: frameSlot = frameSlot;
			move2: frameSlot = frameSlot + 13'd2;
			default: frameSlot = frameSlot + 13'd1;
		endcase

		characterNext = (drawX >= charLeft) && (drawX <= charRight)
			&& (drawY >= charTop) && (drawY <= charBottom);
		spriteNext = characterNext ? spriteAddrT'(drawY - charTop) * spriteStride
			+ spriteAddrT'(drawX - charLeft) + frameSlot * frameWidth : '0;
	end

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			spriteAddr <= '0;
			mapAddr <= '0;
			startAddr <= '0;
			tag <= '0;
		end else begin
			spriteAddr <= spriteNext;
			mapAddr <= mapNext;
			startAddr <= startNext;
			tag <= '{blank, characterNext, inMapNext, gameState == gameOverworld};
		end
	end

endmodule

// File: logic/pixelColor.sv
`timescale 1ns/100ps

module pixelColor import colorMapperPkg::*; (
	input logic Clk,
	input logic rstN,
	input pixelTagT tag,
	input spriteIndexT spriteData,
	input colorIndexT mapData,
	input colorIndexT startData,
	output rgbT rgb
);

	// Tag lines up with the memory read data one cycle later
	pixelTagT tagD;

	// 3-3-2 index to 8 bits per channel by bit replication
	function automatic rgbT expand332(colorIndexT index);
		logic [2:0] r, g;
		logic [1:0] b;
		r = index[7:5];
		g = index[4:2];
		b = index[1:0];
		return {r, r, r[2:1], g, g, g[2:1], b, b, b, b};
	endfunction

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			tagD <= '0;
			rgb <= rgbBlack;
		end else begin
			tagD <= tag;
			if (!tagD.blank) begin
				rgb <= rgbBlack;
			end else if (!tagD.isOverworld) begin
				rgb <= expand332(startData);
			end else if (!tagD.inMap) begin
				rgb <= rgbBlack;
			end else if (tagD.characterHere && spriteData != '0) begin
				rgb <= characterPalette[spriteData];
			end else begin
				rgb <= expand332(mapData);
			end
		end
	end

endmodule

// File: logic/sceneControl.sv
`timescale 1ns/100ps

module sceneControl import colorMapperPkg::*; (
	input logic Clk,
	input logic rstN,
	input logic frameTick,
	input logic [7:0] keycode,
	input cameraStepT step,
	output gameStateT gameState,
	output cameraPosT camera
);

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			gameState <= gameStart;
			camera.x <= '0;
			camera.y <= '0;
		end else if (frameTick) begin
			case (gameState)
				gameStart: begin
					if (keycode == startKey) begin
						gameState <= gameOverworld;
						camera.x <= cameraStart;
						camera.y <= cameraStart;
					end
				end
				default: begin
					// Bounds checked before the move, so max may be passed by one
					if (step.active) begin
						case (step.dir)
							faceUp: begin
								if (camera.y > cameraMinY) camera.y <= camera.y - 1'b1;
							end
							faceDown: begin
								if (camera.y <= cameraMaxY) camera.y <= camera.y + 1'b1;
							end
							faceRight: begin
								if (camera.x <= cameraMaxX) camera.x <= camera.x + 1'b1;
							end
							default: begin
								if (camera.x > cameraMinX) camera.x <= camera.x - 1'b1;
							end
						endcase
					end
				end
			endcase
		end
	end

endmodule

// File: logic/walkAnimator.sv
`timescale 1ns/100ps

module walkAnimator import colorMapperPkg::*; (
	input logic Clk,
	input logic rstN,
	input logic frameTick,
	input logic moving,
	input facingT direction,
	output animFrameT animFrame,
	output cameraStepT step
);

	localparam int delayBits = $clog2(stepPeriod);

	logic [delayBits-1:0] delayCount;
	logic walking;

	// Walking straight ahead, a turn costs one tick with no step
	assign walking = moving && (direction == animFrame.facing);

	always_comb begin
		step.active = frameTick && walking;
		step.dir = animFrame.facing;
	end

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			animFrame.facing <= faceUp;
			animFrame.phase <= rest1;
			delayCount <= '0;
		end else if (frameTick) begin
			if (!moving) begin
				animFrame.phase <= rest1;
			end else if (!walking) begin
				animFrame.facing <= direction;
				animFrame.phase <= rest1;
			end else begin
				if (delayCount == delayBits'(stepPeriod - 1)) begin
					delayCount <= '0;
				end else begin
					delayCount <= delayCount + 1'b1;
				end
				// Phase moves once per stepPeriod steps
				if (delayCount == '0) begin
					case (animFrame.phase)
						rest1: animFrame.phase <= move1;
						move1: animFrame.phase <= rest2;
						rest2: animFrame.phase <= move2;
						default: animFrame.phase <= rest1;
					endcase
				end
			end
		end
	end

endmodule

// File: project.f
logic/colorMapperPkg.sv
logic/walkAnimator.sv
logic/sceneControl.sv
logic/pixelAddressGen.sv
logic/pixelColor.sv
logic/colorMapper.sv
bench/colorMapper_properties.sv
bench/colorMapperTb.sv
